/* bench/tb_tasks.svh */
// Wishbone classic bus tasks and directed tests for the bridge testbench
// Included inside the testbench top module
// Every task is entered and left on a rising edge

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

  // ------------------------------------------------------------------------
  // Checks and reporting
  // ------------------------------------------------------------------------
  task automatic compare_hex(string name, logic [63:0] got, logic [63:0] exp);
    check_count++;
    assert (got === exp) else begin
      err_count++;
      $display("[FAIL] %s got=0x%0h exp=0x%0h", name, got, exp);
    end
  endtask

  task automatic expect_true(bit cond, string what);
    check_count++;
    assert (cond) else begin
      err_count++;
      $display("Error: %s", what);
    end
  endtask

  task automatic note_timeout(string what);
    timeout_count++;
    $display("Timeout: %s", what);
  endtask

  function automatic logic [DATA_W-1:0] shadow_word(logic [APP_AW-1:0] a);
    return exp_mem.exists(a) ? exp_mem[a] : fill_word(a);
  endfunction

  // ------------------------------------------------------------------------
  // Wishbone classic bus tasks
  // ------------------------------------------------------------------------
  task automatic wb_write(logic [APP_AW-1:0] addr, logic [DATA_W-1:0] data,
      logic [DATA_W/8-1:0] sel, output int waits);
    waits = 0;
    exp_cmd.push_back({1'b0, addr});
    exp_wr.push_back({~sel, data});
    exp_mem[addr] = merge_bytes(shadow_word(addr), data, sel);
    wb_stb_i  <= 1'b1;
    wb_cyc_i  <= 1'b1;
    wb_we_i   <= 1'b1;
    wb_addr_i <= addr;
    wb_dat_i  <= data;
    wb_sel_i  <= sel;
    @(negedge sdram_clk);
    while (!wb_ack_o && waits < WAIT_LIMIT) begin
      waits++;
      @(negedge sdram_clk);
    end
    if (!wb_ack_o) begin
      note_timeout("write was never acked");
    end
    // Accepting edge
    @(posedge sdram_clk);
  endtask

  task automatic wb_read(logic [APP_AW-1:0] addr, output logic [DATA_W-1:0] data,
      output int waits);
    waits = 0;
    exp_cmd.push_back({1'b1, addr});
    wb_stb_i  <= 1'b1;
    wb_cyc_i  <= 1'b1;
    wb_we_i   <= 1'b0;
    wb_addr_i <= addr;
    @(negedge sdram_clk);
    while (!wb_ack_o && waits < WAIT_LIMIT) begin
      waits++;
      @(negedge sdram_clk);
    end
    if (!wb_ack_o) begin
      note_timeout("read was never acked");
    end
    data = wb_dat_o;
    @(posedge sdram_clk);
  endtask

  task automatic bus_release();
    wb_stb_i <= 1'b0;
    wb_cyc_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  // Wait for the model to see every issued request, then compare in order
  task automatic drain_compare();
    logic [APP_AW:0]             got_c;
    logic [APP_AW:0]             exp_c;
    logic [DATA_W+DATA_W/8-1:0]  got_w;
    logic [DATA_W+DATA_W/8-1:0]  exp_w;
    int                          waits;
    waits = 0;
    while ((obs_cmd.size() < exp_cmd.size() || obs_wr.size() < exp_wr.size())
           && waits < WAIT_LIMIT) begin
      waits++;
      @(negedge sdram_clk);
    end
    if (obs_cmd.size() < exp_cmd.size() || obs_wr.size() < exp_wr.size()) begin
      note_timeout("model did not receive every issued request");
    end
    // Room for a stray extra command to show up
    repeat (4) @(negedge sdram_clk);
    expect_true(obs_cmd.size() == exp_cmd.size(), "model saw a different number of commands");
    expect_true(obs_wr.size() == exp_wr.size(), "model saw a different number of data words");
    while (obs_cmd.size() > 0 && exp_cmd.size() > 0) begin
      got_c = obs_cmd.pop_front();
      exp_c = exp_cmd.pop_front();
      compare_hex("sdr_req_wr_n_o", got_c[APP_AW], exp_c[APP_AW]);
      compare_hex("sdr_req_addr_o", got_c[APP_AW-1:0], exp_c[APP_AW-1:0]);
    end
    while (obs_wr.size() > 0 && exp_wr.size() > 0) begin
      got_w = obs_wr.pop_front();
      exp_w = exp_wr.pop_front();
      compare_hex("sdr_wr_en_n_o", got_w[DATA_W+:DATA_W/8], exp_w[DATA_W+:DATA_W/8]);
      compare_hex("sdr_wr_data_o", got_w[DATA_W-1:0], exp_w[DATA_W-1:0]);
    end
    obs_cmd.delete();
    exp_cmd.delete();
    obs_wr.delete();
    exp_wr.delete();
    @(posedge sdram_clk);
  endtask

  // ------------------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------------------
  task automatic reset_defaults();
    logic [APP_AW-1:0] addr;
    logic [DATA_W-1:0] rdata;
    int                waits;
    @(negedge sdram_clk);
    compare_hex("sdr_req_o", sdr_req_o, 1'b0);
    compare_hex("sdr_req_len_o", sdr_req_len_o, BL_W'(1));
    @(posedge sdram_clk);
    // Empty read queue holds back the ack of a first read
    addr = APP_AW'($urandom);
    wb_read(addr, rdata, waits);
    bus_release();
    expect_true(waits > 0, "read was acked before its data came back");
    compare_hex("wb_dat_o", rdata, shadow_word(addr));
    drain_compare();
  endtask

  task automatic single_write();
    logic [APP_AW-1:0]   addr;
    logic [DATA_W-1:0]   data;
    logic [DATA_W/8-1:0] sel;
    int                  waits;
    addr = APP_AW'($urandom);
    data = $urandom;
    sel  = 4'b1011;
    wb_write(addr, data, sel, waits);
    bus_release();
    expect_true(waits == 0, "write was not acked in the cycle it was offered");
    // Entry shows on the request side one cycle after acceptance
    @(negedge sdram_clk);
    compare_hex("sdr_req_o", sdr_req_o, 1'b1);
    compare_hex("sdr_req_addr_o", sdr_req_addr_o, addr);
    compare_hex("sdr_req_wr_n_o", sdr_req_wr_n_o, 1'b0);
    compare_hex("sdr_wr_data_o", sdr_wr_data_o, data);
    compare_hex("sdr_wr_en_n_o", sdr_wr_en_n_o, (DATA_W/8)'(~sel));
    @(posedge sdram_clk);
    drain_compare();
  endtask

  task automatic read_after_write();
    logic [APP_AW-1:0] addr;
    logic [DATA_W-1:0] rdata;
    int                waits;
    addr = APP_AW'($urandom);
    wb_write(addr, $urandom, 4'hf, waits);
    wb_write(addr, $urandom, 4'b0101, waits);
    wb_read(addr, rdata, waits);
    compare_hex("wb_dat_o", rdata, shadow_word(addr));
    // Partial write onto untouched memory
    wb_write(addr + 1'b1, $urandom, 4'b1000, waits);
    wb_read(addr + 1'b1, rdata, waits);
    bus_release();
    compare_hex("wb_dat_o", rdata, shadow_word(addr + 1'b1));
    drain_compare();
  endtask

  task automatic writes_then_read();
    logic [APP_AW-1:0] base;
    logic [DATA_W-1:0] rdata;
    int                waits;
    base = APP_AW'($urandom);
    wb_write(base, $urandom, 4'hf, waits);
    wb_write(base + APP_AW'(1), $urandom, 4'hf, waits);
    wb_write(base, $urandom, 4'b0110, waits);
    wb_write(base + APP_AW'(2), $urandom, 4'hf, waits);
    wb_read(base, rdata, waits);
    bus_release();
    compare_hex("wb_dat_o", rdata, shadow_word(base));
    drain_compare();
  endtask

  task automatic back_pressure();
    logic [APP_AW-1:0] base;
    int                waits;
    base = APP_AW'($urandom);
    ack_en <= 1'b0;
    for (int i = 0; i < CMD_DEPTH; i++) begin
      wb_write(base + APP_AW'(i), $urandom, 4'hf, waits);
      expect_true(waits == 0, "write refused while the command queue had room");
    end
    // Next write stalls until the model acks again
    fork
      wb_write(base + APP_AW'(CMD_DEPTH), $urandom, 4'hf, waits);
      begin
        for (int i = 0; i < STALL_CYCLES; i++) begin
          @(negedge sdram_clk);
          compare_hex("wb_ack_o", wb_ack_o, 1'b0);
        end
        @(posedge sdram_clk);
        ack_en <= 1'b1;
      end
    join
    bus_release();
    expect_true(waits >= STALL_CYCLES, "write was acked while the command queue was full");
    drain_compare();
  endtask

`endif

/* bench/tb_wb2sdr.sv */
// Testbench for the Wishbone to SDRAM bridge, with a simple SDRAM controller model
// Runs the directed tests from tb_tasks.svh and prints the closing report

module tb_wb2sdr import wb2sdr_pkg::*; ();

  localparam int WAIT_LIMIT   = 50;
  localparam int STALL_CYCLES = 8;

  // ------------------------------------------------------------------------
  // DUT signals
  // ------------------------------------------------------------------------
  logic                sdram_clk = 1'b0;
  logic                wb_clk_i;
  logic                wb_stb_i;
  logic                wb_cyc_i;
  logic                wb_we_i;
  logic [APP_AW-1:0]   wb_addr_i;
  logic [DATA_W-1:0]   wb_dat_i;
  logic [DATA_W/8-1:0] wb_sel_i;
  logic                wb_ack_o;
  logic [DATA_W-1:0]   wb_dat_o;
  logic                sdr_req_o;
  logic [APP_AW-1:0]   sdr_req_addr_o;
  logic [BL_W-1:0]     sdr_req_len_o;
  logic                sdr_req_wr_n_o;
  logic [DATA_W/8-1:0] sdr_wr_en_n_o;
  logic [DATA_W-1:0]   sdr_wr_data_o;

  // Driven by the controller model
  logic                sdr_req_ack_i  = 1'b0;
  logic                sdr_wr_next_i  = 1'b0;
  logic                sdr_rd_valid_i = 1'b0;
  logic [DATA_W-1:0]   sdr_rd_data_i  = '0;

  // ------------------------------------------------------------------------
  // Model state and scoreboard
  // ------------------------------------------------------------------------
  logic                ack_en = 1'b1;
  logic [DATA_W-1:0]   mem [logic [APP_AW-1:0]];
  logic [APP_AW-1:0]   rd_addr = '0;
  int                  rd_delay = -1;

  // Expected word per address, kept by the bus tasks
  logic [DATA_W-1:0]   exp_mem [logic [APP_AW-1:0]];
  // {wr_n, addr} and {mask, data}, issued vs seen by the model
  logic [APP_AW:0]     exp_cmd [$];
  logic [APP_AW:0]     obs_cmd [$];
  logic [DATA_W+DATA_W/8-1:0] exp_wr [$];
  logic [DATA_W+DATA_W/8-1:0] obs_wr [$];

  int check_count   = 0;
  int err_count     = 0;
  int timeout_count = 0;

  // Untouched memory, pattern built from every address bit
  function automatic logic [DATA_W-1:0] fill_word(logic [APP_AW-1:0] a);
    return {a, 6'h2b} ^ 32'h9e37_79b9;
  endfunction

  function automatic logic [DATA_W-1:0] mem_word(logic [APP_AW-1:0] a);
    return mem.exists(a) ? mem[a] : fill_word(a);
  endfunction

  // Byte lanes with en high take the new word
  function automatic logic [DATA_W-1:0] merge_bytes(logic [DATA_W-1:0] old_w,
      logic [DATA_W-1:0] new_w, logic [DATA_W/8-1:0] en);
    logic [DATA_W-1:0] res;
    res = old_w;
    for (int i = 0; i < DATA_W / 8; i++) begin
      if (en[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  `include "tb_tasks.svh"

  wb2sdr_top i_dut (.*);

  always #50 sdram_clk = ~sdram_clk;

  // ------------------------------------------------------------------------
  // SDRAM controller model
  // ------------------------------------------------------------------------
  always @(posedge sdram_clk) begin
    sdr_req_ack_i  <= 1'b0;
    sdr_wr_next_i  <= 1'b0;
    sdr_rd_valid_i <= 1'b0;
    if (wb_clk_i) begin
      rd_delay = -1;
    end else begin
      // One ack per request, never on back-to-back edges
      if (sdr_req_o && ack_en && !sdr_req_ack_i) begin
        sdr_req_ack_i <= 1'b1;
        obs_cmd.push_back({sdr_req_wr_n_o, sdr_req_addr_o});
        if (!sdr_req_wr_n_o) begin
          sdr_wr_next_i <= 1'b1;
          obs_wr.push_back({sdr_wr_en_n_o, sdr_wr_data_o});
          mem[sdr_req_addr_o] = merge_bytes(mem_word(sdr_req_addr_o), sdr_wr_data_o,
                                            ~sdr_wr_en_n_o);
        end else begin
          // Latency varies with the low address bits
          rd_addr  = sdr_req_addr_o;
          rd_delay = 2 + int'(sdr_req_addr_o[1:0]);
        end
      end
      if (rd_delay == 0) begin
        sdr_rd_valid_i <= 1'b1;
        sdr_rd_data_i  <= mem_word(rd_addr);
      end
      if (rd_delay >= 0) begin
        rd_delay = rd_delay - 1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial begin
    void'($urandom(32'hbc6e0bc3));
    wb_clk_i  = 1'b1;
    wb_stb_i  = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_addr_i = '0;
    wb_dat_i  = '0;
    wb_sel_i  = '0;
    repeat (4) @(posedge sdram_clk);
    wb_clk_i <= 1'b0;
    @(posedge sdram_clk);

    reset_defaults();
    single_write();
    read_after_write();
    writes_then_read();
    back_pressure();

    $display("checks=%0d errors=%0d timeouts=%0d", check_count, err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+bench
src/wb2sdr_pkg.sv
src/fifo_if.sv
src/sync_fifo.sv
src/wb_req_ctrl.sv
src/wb2sdr_top.sv
bench/tb_wb2sdr.sv

/* run.sh */
#!/usr/bin/env bash
# Compile the bridge testbench with Verilator, run it, and judge the log
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 -Wno-fatal --top-module tb_wb2sdr \
    -f list.f -o sim_tb; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_tb > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi

cat sim.log

if grep -qx "Verification passed" sim.log; then
  echo "Result: PASS"
  exit 0
else
  echo "Result: FAIL"
  exit 1
fi

/* src/fifo_if.sv */
// Push/pop handshake between a queue, its producer and its consumer
// Push only while full is low, pop only while empty is low

interface fifo_if #(
  parameter int W = 8
);

  // Producer side
  logic         push;
  logic [W-1:0] wdata;
  logic         full;

  // Consumer side, rdata always shows the head
  logic         pop;
  logic [W-1:0] rdata;
  logic         empty;

  modport producer (
    output push,
    output wdata,
    input  full
  );

  modport consumer (
    output pop,
    input  rdata,
    input  empty
  );

  // Queue storage itself
  modport fifo (
    input  push,
    input  wdata,
    input  pop,
    output full,
    output rdata,
    output empty
  );

endinterface

/* src/sync_fifo.sv */
// Show-ahead synchronous FIFO with full and empty flags
// Head entry is visible on rdata with no read latency

module sync_fifo #(
  parameter int W     = 8,
  parameter int DEPTH = 4
) (
  input  logic sdram_clk,
  input  logic wb_clk_i,
  fifo_if.fifo q
);

  // Pointer and occupancy widths
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [W-1:0]  mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;

  logic do_push;
  logic do_pop;

  // Requests outside the handshake are ignored
  assign do_push = q.push & ~q.full;
  assign do_pop  = q.pop & ~q.empty;

  // Flags straight from occupancy
  assign q.full  = (count == CW'(DEPTH));
  assign q.empty = (count == '0);

  // Head of queue
  assign q.rdata = mem[rd_ptr];

  // ------------------------------------------------------------------------
  // Storage array
  // ------------------------------------------------------------------------
  always_ff @(posedge sdram_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= q.wdata;
    end
  end

  // ------------------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------------------
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Ring wrap, depth need not be a power of two
      if (do_push) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keeps count
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* src/wb2sdr_pkg.sv */
// Shared sizes, queue depths and request encodings for the Wishbone to SDRAM bridge
// Imported by the bridge top, the request controller and the testbench

package wb2sdr_pkg;

  // ------------------------------------------------------------------------
  // Default data path sizes
  // ------------------------------------------------------------------------
  localparam int DATA_W = 32;
  localparam int APP_AW = 26;

  // Burst length field towards the controller
  localparam int BL_W = 9;
  // Every request is one transfer
  localparam logic [BL_W-1:0] BURST_LEN_SINGLE = BL_W'(1);

  // ------------------------------------------------------------------------
  // Default queue depths
  // ------------------------------------------------------------------------
  localparam int CMD_DEPTH = 4;
  localparam int WR_DEPTH  = 8;
  localparam int RD_DEPTH  = 4;

  // Request direction, same sense as the active-low write strobe
  typedef enum logic {
    SDR_WRITE = 1'b0,
    SDR_READ  = 1'b1
  } sdr_dir_e;

endpackage

/* src/wb2sdr_top.sv */
// Wishbone classic to SDRAM controller request bridge
// Three queues carry commands, write data and read data between the two sides

module wb2sdr_top import wb2sdr_pkg::*; #(
  parameter int DW        = DATA_W,
  parameter int AW        = APP_AW,
  parameter int CMD_DEPTH = wb2sdr_pkg::CMD_DEPTH,
  parameter int WR_DEPTH  = wb2sdr_pkg::WR_DEPTH,
  parameter int RD_DEPTH  = wb2sdr_pkg::RD_DEPTH
) (
  input  logic            sdram_clk,
  input  logic            wb_clk_i,

  // Wishbone classic slave
  input  logic            wb_stb_i,
  input  logic            wb_cyc_i,
  input  logic            wb_we_i,
  input  logic [AW-1:0]   wb_addr_i,
  input  logic [DW-1:0]   wb_dat_i,
  input  logic [DW/8-1:0] wb_sel_i,
  output logic            wb_ack_o,
  output logic [DW-1:0]   wb_dat_o,

  // SDRAM controller request handshake
  output logic            sdr_req_o,
  output logic [AW-1:0]   sdr_req_addr_o,
  output logic [BL_W-1:0] sdr_req_len_o,
  output logic            sdr_req_wr_n_o,
  input  logic            sdr_req_ack_i,

  // SDRAM controller data handshake
  output logic [DW/8-1:0] sdr_wr_en_n_o,
  input  logic            sdr_wr_next_i,
  input  logic            sdr_rd_valid_i,
  output logic [DW-1:0]   sdr_wr_data_o,
  input  logic [DW-1:0]   sdr_rd_data_i
);

  // ------------------------------------------------------------------------
  // Queue channels
  // ------------------------------------------------------------------------
  // Direction + address
  fifo_if #(.W(AW + 1))        cmd_if ();
  // Byte mask + data
  fifo_if #(.W(DW + DW / 8))   wr_if ();
  // Read data only
  fifo_if #(.W(DW))            rd_if ();

  // Wishbone side control
  wb_req_ctrl #(
    .DW (DW),
    .AW (AW)
  ) u_req_ctrl (
    .sdram_clk (sdram_clk),
    .wb_clk_i  (wb_clk_i),
    .wb_stb_i  (wb_stb_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_we_i   (wb_we_i),
    .wb_addr_i (wb_addr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_sel_i  (wb_sel_i),
    .wb_ack_o  (wb_ack_o),
    .wb_dat_o  (wb_dat_o),
    .cmd_q     (cmd_if.producer),
    .wr_q      (wr_if.producer),
    .rd_q      (rd_if.consumer)
  );

  // ------------------------------------------------------------------------
  // Command queue
  // ------------------------------------------------------------------------
  sync_fifo #(.W(AW + 1), .DEPTH(CMD_DEPTH)) u_cmdfifo (
    .sdram_clk (sdram_clk),
    .wb_clk_i  (wb_clk_i),
    .q         (cmd_if.fifo)
  );

  // Request held while anything is queued
  assign sdr_req_o  = ~cmd_if.empty;
  // Controller ack retires the head
  assign cmd_if.pop = sdr_req_ack_i;
  assign {sdr_req_wr_n_o, sdr_req_addr_o} = cmd_if.rdata;

  // Single transfer per request
  assign sdr_req_len_o = BURST_LEN_SINGLE;

  // ------------------------------------------------------------------------
  // Write data queue
  // ------------------------------------------------------------------------
  sync_fifo #(.W(DW + DW / 8), .DEPTH(WR_DEPTH)) u_wrdatafifo (
    .sdram_clk (sdram_clk),
    .wb_clk_i  (wb_clk_i),
    .q         (wr_if.fifo)
  );

  // Next head on controller write strobe
  assign wr_if.pop = sdr_wr_next_i;
  assign {sdr_wr_en_n_o, sdr_wr_data_o} = wr_if.rdata;

  // ------------------------------------------------------------------------
  // Read data queue
  // ------------------------------------------------------------------------
  sync_fifo #(.W(DW), .DEPTH(RD_DEPTH)) u_rddatafifo (
    .sdram_clk (sdram_clk),
    .wb_clk_i  (wb_clk_i),
    .q         (rd_if.fifo)
  );

  // Captured on every controller read strobe
  assign rd_if.push  = sdr_rd_valid_i;
  assign rd_if.wdata = sdr_rd_data_i;

endmodule

/* src/wb_req_ctrl.sv */
// Wishbone classic slave side of the bridge
// Generates ack, tracks the one outstanding read and drives queue push/pop

module wb_req_ctrl import wb2sdr_pkg::*; #(
  parameter int DW = 32,
  parameter int AW = 26
) (
  input  logic            sdram_clk,
  input  logic            wb_clk_i,

  // Wishbone slave
  input  logic            wb_stb_i,
  input  logic            wb_cyc_i,
  input  logic            wb_we_i,
  input  logic [AW-1:0]   wb_addr_i,
  input  logic [DW-1:0]   wb_dat_i,
  input  logic [DW/8-1:0] wb_sel_i,
  output logic            wb_ack_o,
  output logic [DW-1:0]   wb_dat_o,

  // Queues
  fifo_if.producer        cmd_q,
  fifo_if.producer        wr_q,
  fifo_if.consumer        rd_q
);

  logic     wr_phase;
  logic     rd_phase;
  logic     wr_room;
  logic     wr_accept;
  logic     rd_issue;
  logic     rd_ack;
  logic     pending_read;
  sdr_dir_e req_dir;

  // ------------------------------------------------------------------------
  // Cycle decode
  // ------------------------------------------------------------------------
  assign wr_phase = wb_stb_i & wb_cyc_i & wb_we_i;
  assign rd_phase = wb_stb_i & wb_cyc_i & ~wb_we_i;

  // Write needs a slot in both command and data queues
  assign wr_room   = ~cmd_q.full & ~wr_q.full;
  assign wr_accept = wr_phase & wr_room;

  // Only one read command per Wishbone read
  assign rd_issue = rd_phase & ~cmd_q.full & ~pending_read;

  // Read ends once data is waiting
  assign rd_ack = rd_phase & ~rd_q.empty;

  // Write acked on entry, read acked with data
  assign wb_ack_o = wr_accept | rd_ack;

  // ------------------------------------------------------------------------
  // Command queue push
  // ------------------------------------------------------------------------
  assign req_dir = wb_we_i ? SDR_WRITE : SDR_READ;

  assign cmd_q.push  = wr_accept | rd_issue;
  // Direction bit above address
  assign cmd_q.wdata = {req_dir, wb_addr_i};

  // ------------------------------------------------------------------------
  // Write data queue push
  // ------------------------------------------------------------------------
  assign wr_q.push  = wr_accept;
  // Active-low byte mask above data
  assign wr_q.wdata = {~wb_sel_i, wb_dat_i};

  // ------------------------------------------------------------------------
  // Read data return
  // ------------------------------------------------------------------------
  assign rd_q.pop = rd_ack;
  assign wb_dat_o = rd_q.rdata;

  // Pending read
  // set on read command push, cleared by the read ack
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      pending_read <= 1'b0;
    end else if (rd_issue) begin
      pending_read <= 1'b1;
    end else if (rd_ack) begin
      pending_read <= 1'b0;
    end
  end

endmodule
